//--- source/sb_pkg.sv
// ------------------------------
// scoreboard package
// queue depth, register file and data sizes, and the
// functional-unit codes shared by all scoreboard blocks
// ------------------------------
`default_nettype none

package sb_pkg;

  // queue depth, must stay a power of two
  localparam int unsigned NR_ENTRIES    = 8;
  // transaction id and pointer width
  localparam int unsigned ENTRY_BITS    = 3;

  // general-purpose register file
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned NR_REGS       = 32;
  localparam int unsigned XLEN          = 32;

  // write-back ports from the functional units
  localparam int unsigned NR_WB_PORTS   = 2;

  // ------------------------------
  // functional-unit codes
  // ------------------------------
  // FU_NONE entries need no write-back and complete by themselves
  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_BRANCH = 3'd2,
    FU_LOAD   = 3'd3,
    FU_STORE  = 3'd4,
    FU_MULT   = 3'd5,
    FU_CSR    = 3'd6
  } fu_e;

endpackage

`default_nettype wire

//--- source/sb_queue_ctrl.sv
// ------------------------------
// scoreboard queue control
// issue and commit pointers, occupancy count, full flag
// and the issue handshake towards the decoder
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module sb_queue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          decoded_valid_i,
  input  logic                          unresolved_branch_i,
  input  logic                          issue_ack_i,
  input  logic                          flush_unissued_i,
  input  logic                          flush_i,
  input  logic                          commit_ack_i,
  output logic                          issue_valid_o,
  output logic                          decoded_ack_o,
  output logic                          sb_full_o,
  output logic                          issue_en_o,
  output logic [sb_pkg::ENTRY_BITS-1:0] issue_ptr_o,
  output logic [sb_pkg::ENTRY_BITS-1:0] commit_ptr_o
);

  logic [sb_pkg::ENTRY_BITS-1:0] issue_ptr_q;
  logic [sb_pkg::ENTRY_BITS-1:0] commit_ptr_q;
  // one bit wider than the pointers, top bit set means full
  logic [sb_pkg::ENTRY_BITS:0]   cnt_q;

  assign sb_full_o = cnt_q[sb_pkg::ENTRY_BITS];

  // issue is held back by a full queue or a pending branch
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~sb_full_o;
  assign decoded_ack_o = issue_ack_i & ~sb_full_o;
  // accepted instruction goes into the slot at the issue pointer
  assign issue_en_o    = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  assign issue_ptr_o  = issue_ptr_q;
  assign commit_ptr_o = commit_ptr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      // pointers wrap naturally on the power-of-two depth
      if (issue_en_o) begin
        issue_ptr_q <= issue_ptr_q + 1'b1;
      end
      if (commit_ack_i) begin
        commit_ptr_q <= commit_ptr_q + 1'b1;
      end
      // issue and commit in one cycle leave the count alone
      case ({issue_en_o, commit_ack_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // the issue stage only acknowledges what was offered to it
  a_issue_ack_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o
  ) else $error("issue ack without a valid issue");

endmodule

`default_nettype wire

//--- source/sb_entry_store.sv
// ------------------------------
// scoreboard entry store
// per-slot flags and payload, written on issue,
// completed by write-back, freed on commit or flush
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module sb_entry_store (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic                                                      issue_en_i,
  input  logic [sb_pkg::ENTRY_BITS-1:0]                             issue_ptr_i,
  input  logic [sb_pkg::ENTRY_BITS-1:0]                             commit_ptr_i,
  input  logic                                                      commit_ack_i,
  input  logic                                                      flush_i,
  input  sb_pkg::fu_e                                               decoded_fu_i,
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          decoded_rd_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::ENTRY_BITS-1:0]    wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]          wb_data_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_ex_i,
  output logic [sb_pkg::NR_ENTRIES-1:0]                             issued_o,
  output logic [sb_pkg::NR_ENTRIES-1:0]                             done_o,
  output sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]                      fu_o,
  output logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0]  rd_o,
  output logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]           result_o,
  output logic [sb_pkg::NR_ENTRIES-1:0]                             ex_o
);

  // control flags
  logic [sb_pkg::NR_ENTRIES-1:0] issued_q, issued_d;
  logic [sb_pkg::NR_ENTRIES-1:0] done_q, done_d;
  logic [sb_pkg::NR_ENTRIES-1:0] ex_q, ex_d;
  // payload
  sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]                     fu_q, fu_d;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0] rd_q, rd_d;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]          result_q, result_d;

  always_comb begin
    issued_d = issued_q;
    done_d   = done_q;
    ex_d     = ex_q;
    fu_d     = fu_q;
    rd_d     = rd_q;
    result_d = result_q;

    // ------------------------------
    // issue into the free slot
    // ------------------------------
    if (issue_en_i) begin
      issued_d[issue_ptr_i] = 1'b1;
      done_d[issue_ptr_i]   = 1'b0;
      ex_d[issue_ptr_i]     = 1'b0;
      fu_d[issue_ptr_i]     = decoded_fu_i;
      rd_d[issue_ptr_i]     = decoded_rd_i;
    end

    // no unit behind it, so done one cycle after issue
    for (int unsigned i = 0; i < sb_pkg::NR_ENTRIES; i++) begin
      if (issued_q[i] && fu_q[i] == sb_pkg::FU_NONE) begin
        done_d[i] = 1'b1;
      end
    end

    // ------------------------------
    // write-back
    // ------------------------------
    // stale results for freed slots are dropped
    for (int unsigned k = 0; k < sb_pkg::NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        done_d[wb_trans_id_i[k]]   = 1'b1;
        result_d[wb_trans_id_i[k]] = wb_data_i[k];
        ex_d[wb_trans_id_i[k]]     = wb_ex_i[k];
      end
    end

    // retire the oldest entry
    if (commit_ack_i) begin
      issued_d[commit_ptr_i] = 1'b0;
      done_d[commit_ptr_i]   = 1'b0;
    end

    // flush wins over everything above
    if (flush_i) begin
      issued_d = '0;
      done_d   = '0;
      ex_d     = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= '0;
      done_q   <= '0;
      ex_q     <= '0;
    end else begin
      issued_q <= issued_d;
      done_q   <= done_d;
      ex_q     <= ex_d;
    end
  end

  always_ff @(posedge clk_i) begin
    fu_q     <= fu_d;
    rd_q     <= rd_d;
    result_q <= result_d;
  end

  assign issued_o = issued_q;
  assign done_o   = done_q;
  assign ex_o     = ex_q;
  assign fu_o     = fu_q;
  assign rd_o     = rd_q;
  assign result_o = result_q;

  // two units never finish the same instruction
  for (genvar i = 0; i < sb_pkg::NR_WB_PORTS; i++) begin : g_wb_i
    for (genvar j = i + 1; j < sb_pkg::NR_WB_PORTS; j++) begin : g_wb_j
      a_wb_unique_id : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_valid_i[i] && wb_valid_i[j] |-> wb_trans_id_i[i] != wb_trans_id_i[j]
      ) else $error("write-back ports %0d and %0d share a trans id", i, j);
    end
  end

  // commit stage only retires completed work
  a_commit_done : assert property (
    @(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> done_q[commit_ptr_i]
  ) else $error("commit ack on an entry that is not done");

endmodule

`default_nettype wire

//--- source/sb_clobber_map.sv
// ------------------------------
// scoreboard clobber map
// per register, the unit that will write it next
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module sb_clobber_map (
  input  logic [sb_pkg::NR_ENTRIES-1:0]                            issued_i,
  input  sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]                     fu_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0] rd_i,
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]                        rd_clobber_o
);

  always_comb begin
    for (int unsigned r = 0; r < sb_pkg::NR_REGS; r++) begin
      rd_clobber_o[r] = sb_pkg::FU_NONE;
    end
    // walk down so the lowest matching slot is written last and wins
    for (int e = sb_pkg::NR_ENTRIES - 1; e >= 0; e--) begin
      // x0 is hardwired, writers to it are never tracked
      if (issued_i[e] && rd_i[e] != '0) begin
        rd_clobber_o[rd_i[e]] = fu_i[e];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/sb_operand_fwd.sv
// ------------------------------
// scoreboard operand forwarding
// rs1/rs2 values from write-back ports in flight or
// from completed entries, fixed priority
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module sb_operand_fwd (
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          rs1_i,
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                          rs2_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0]                             issued_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0]                             done_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0]  rd_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]           result_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::ENTRY_BITS-1:0]    wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]          wb_data_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                            wb_ex_i,
  output logic [sb_pkg::XLEN-1:0]                                   rs1_o,
  output logic                                                      rs1_valid_o,
  output logic [sb_pkg::XLEN-1:0]                                   rs2_o,
  output logic                                                      rs2_valid_o
);

  // index 0 is rs1, index 1 is rs2
  logic [1:0][sb_pkg::REG_ADDR_BITS-1:0] rs_addr;
  logic [1:0][sb_pkg::XLEN-1:0]          rs_data;
  logic [1:0]                            rs_hit;

  assign rs_addr[0] = rs1_i;
  assign rs_addr[1] = rs2_i;

  // lowest priority is checked first, later hits overwrite
  always_comb begin
    rs_hit  = '0;
    rs_data = '0;
    for (int j = 0; j < 2; j++) begin
      // ------------------------------
      // completed entries, lowest index wins
      // ------------------------------
      for (int e = sb_pkg::NR_ENTRIES - 1; e >= 0; e--) begin
        if (issued_i[e] && done_i[e] && rd_i[e] == rs_addr[j]) begin
          rs_hit[j]  = 1'b1;
          rs_data[j] = result_i[e];
        end
      end
      // ------------------------------
      // write-back ports beat entries, port 0 first
      // ------------------------------
      // a faulting result must not reach a dependent instruction
      for (int k = sb_pkg::NR_WB_PORTS - 1; k >= 0; k--) begin
        if (wb_valid_i[k] && !wb_ex_i[k] && rd_i[wb_trans_id_i[k]] == rs_addr[j]) begin
          rs_hit[j]  = 1'b1;
          rs_data[j] = wb_data_i[k];
        end
      end
    end
  end

  assign rs1_o = rs_data[0];
  assign rs2_o = rs_data[1];

  // x0 is read from the register file, never forwarded
  assign rs1_valid_o = rs_hit[0] & (|rs1_i);
  assign rs2_valid_o = rs_hit[1] & (|rs2_i);

endmodule

`default_nettype wire

//--- source/scoreboard_top.sv
// ------------------------------
// scoreboard top level
// in-order issue and commit tracker for up to eight
// instructions, with clobber map and operand forwarding
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module scoreboard_top (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // decoder and issue stage
  input  logic                                                    decoded_valid_i,
  input  sb_pkg::fu_e                                             decoded_fu_i,
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                        decoded_rd_i,
  input  logic                                                    unresolved_branch_i,
  input  logic                                                    issue_ack_i,
  input  logic                                                    flush_unissued_i,
  output logic                                                    issue_valid_o,
  output logic                                                    decoded_ack_o,
  output logic [sb_pkg::ENTRY_BITS-1:0]                           issue_trans_id_o,
  // functional-unit write-back
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                          wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::ENTRY_BITS-1:0]  wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]        wb_data_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                          wb_ex_i,
  // commit stage
  output logic                                                    commit_valid_o,
  output sb_pkg::fu_e                                             commit_fu_o,
  output logic [sb_pkg::REG_ADDR_BITS-1:0]                        commit_rd_o,
  output logic [sb_pkg::XLEN-1:0]                                 commit_result_o,
  output logic                                                    commit_ex_o,
  output logic [sb_pkg::ENTRY_BITS-1:0]                           commit_trans_id_o,
  input  logic                                                    commit_ack_i,
  // status and flush
  input  logic                                                    flush_i,
  output logic                                                    sb_full_o,
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]                       rd_clobber_o,
  // operand read
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                        rs1_i,
  input  logic [sb_pkg::REG_ADDR_BITS-1:0]                        rs2_i,
  output logic [sb_pkg::XLEN-1:0]                                 rs1_o,
  output logic                                                    rs1_valid_o,
  output logic [sb_pkg::XLEN-1:0]                                 rs2_o,
  output logic                                                    rs2_valid_o
);

  logic                                                     issue_en;
  logic [sb_pkg::ENTRY_BITS-1:0]                            issue_ptr;
  logic [sb_pkg::ENTRY_BITS-1:0]                            commit_ptr;
  logic [sb_pkg::NR_ENTRIES-1:0]                            issued;
  logic [sb_pkg::NR_ENTRIES-1:0]                            done;
  sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]                     fu;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_BITS-1:0] rd;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]          result;
  logic [sb_pkg::NR_ENTRIES-1:0]                            ex;

  sb_queue_ctrl u_queue_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .decoded_valid_i     (decoded_valid_i),
    .unresolved_branch_i (unresolved_branch_i),
    .issue_ack_i         (issue_ack_i),
    .flush_unissued_i    (flush_unissued_i),
    .flush_i             (flush_i),
    .commit_ack_i        (commit_ack_i),
    .issue_valid_o       (issue_valid_o),
    .decoded_ack_o       (decoded_ack_o),
    .sb_full_o           (sb_full_o),
    .issue_en_o          (issue_en),
    .issue_ptr_o         (issue_ptr),
    .commit_ptr_o        (commit_ptr)
  );

  sb_entry_store u_entry_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_en_i    (issue_en),
    .issue_ptr_i   (issue_ptr),
    .commit_ptr_i  (commit_ptr),
    .commit_ack_i  (commit_ack_i),
    .flush_i       (flush_i),
    .decoded_fu_i  (decoded_fu_i),
    .decoded_rd_i  (decoded_rd_i),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .wb_ex_i       (wb_ex_i),
    .issued_o      (issued),
    .done_o        (done),
    .fu_o          (fu),
    .rd_o          (rd),
    .result_o      (result),
    .ex_o          (ex)
  );

  sb_clobber_map u_clobber_map (
    .issued_i     (issued),
    .fu_i         (fu),
    .rd_i         (rd),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd u_operand_fwd (
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .issued_i      (issued),
    .done_i        (done),
    .rd_i          (rd),
    .result_i      (result),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .wb_ex_i       (wb_ex_i),
    .rs1_o         (rs1_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_o         (rs2_o),
    .rs2_valid_o   (rs2_valid_o)
  );

  // transaction id is simply the slot index
  assign issue_trans_id_o = issue_ptr;

  // ------------------------------
  // commit port, oldest entry
  // ------------------------------
  assign commit_valid_o    = done[commit_ptr];
  assign commit_fu_o       = fu[commit_ptr];
  assign commit_rd_o       = rd[commit_ptr];
  assign commit_result_o   = result[commit_ptr];
  assign commit_ex_o       = ex[commit_ptr];
  assign commit_trans_id_o = commit_ptr;

endmodule

`default_nettype wire

//--- tests/tb_scoreboard.sv
// ------------------------------
// scoreboard testbench
// directed tests for issue, write-back, commit, clobber
// map, forwarding and flush against a small entry model
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_scoreboard;

  // six short tests need a few hundred cycles, ample margin on top
  localparam int WATCHDOG_CYCLES = 3000;

  logic clk_i, rst_ni;
  logic decoded_valid_i, unresolved_branch_i, issue_ack_i, flush_unissued_i;
  logic commit_ack_i, flush_i;
  sb_pkg::fu_e decoded_fu_i;
  logic [sb_pkg::REG_ADDR_BITS-1:0] decoded_rd_i, rs1_i, rs2_i;
  logic [sb_pkg::NR_WB_PORTS-1:0] wb_valid_i, wb_ex_i;
  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::ENTRY_BITS-1:0] wb_trans_id_i;
  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0] wb_data_i;
  logic issue_valid_o, decoded_ack_o, commit_valid_o, commit_ex_o, sb_full_o;
  logic [sb_pkg::ENTRY_BITS-1:0] issue_trans_id_o, commit_trans_id_o;
  sb_pkg::fu_e commit_fu_o;
  logic [sb_pkg::REG_ADDR_BITS-1:0] commit_rd_o;
  logic [sb_pkg::XLEN-1:0] commit_result_o, rs1_o, rs2_o;
  logic rs1_valid_o, rs2_valid_o;
  sb_pkg::fu_e [sb_pkg::NR_REGS-1:0] rd_clobber_o;

  // ------------------------------
  // reference model of the queue
  // ------------------------------
  logic [7:0] m_issued, m_wb, m_ex;
  sb_pkg::fu_e m_fu [8];
  logic [4:0] m_rd [8];
  logic [31:0] m_res [8];
  int head, tail, cnt;
  int errors, checks;
  string test_name;
  logic [31:0] lcg_state;

  scoreboard_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  // next falling edge, all strobes back to idle
  task automatic finish_cycle();
    @(negedge clk_i);
    decoded_valid_i = 1'b0;
    issue_ack_i = 1'b0;
    unresolved_branch_i = 1'b0;
    flush_unissued_i = 1'b0;
    flush_i = 1'b0;
    commit_ack_i = 1'b0;
    wb_valid_i = '0;
    wb_ex_i = '0;
  endtask

  task automatic issue_one(input sb_pkg::fu_e fu, input logic [4:0] rd);
    @(negedge clk_i);
    decoded_valid_i = 1'b1;
    issue_ack_i = 1'b1;
    decoded_fu_i = fu;
    decoded_rd_i = rd;
    #1;
    expect_eq("issue valid", 1, issue_valid_o);
    expect_eq("decoded ack", 1, decoded_ack_o);
    expect_eq("issue trans id", tail, issue_trans_id_o);
    m_issued[tail] = 1'b1;
    m_wb[tail] = 1'b0;
    m_ex[tail] = 1'b0;
    m_fu[tail] = fu;
    m_rd[tail] = rd;
    tail = (tail + 1) % 8;
    cnt++;
    finish_cycle();
  endtask

  // drives one port in the current cycle, model follows the issued check
  task automatic drive_wb(input int p, input int id, input logic [31:0] d, input logic e);
    wb_valid_i[p] = 1'b1;
    wb_trans_id_i[p] = 3'(id);
    wb_data_i[p] = d;
    wb_ex_i[p] = e;
    if (m_issued[id]) begin
      m_res[id] = d;
      m_ex[id] = e;
      m_wb[id] = 1'b1;
    end
  endtask

  task automatic write_back(input int p, input int id, input logic [31:0] d, input logic e);
    @(negedge clk_i);
    drive_wb(p, id, d, e);
    finish_cycle();
  endtask

  task automatic commit_one();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!commit_valid_o && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!commit_valid_o) begin
      errors++;
      $display("%s: commit valid never rose for entry %0d", test_name, head);
      return;
    end
    expect_eq("commit trans id", head, commit_trans_id_o);
    expect_eq("commit fu", m_fu[head], commit_fu_o);
    expect_eq("commit rd", m_rd[head], commit_rd_o);
    expect_eq("commit ex", m_ex[head], commit_ex_o);
    if (m_wb[head]) begin
      expect_eq("commit result", m_res[head], commit_result_o);
    end
    commit_ack_i = 1'b1;
    m_issued[head] = 1'b0;
    head = (head + 1) % 8;
    cnt--;
    finish_cycle();
  endtask

  // complete whatever is pending with random data and retire it
  task automatic drain();
    while (cnt > 0) begin
      if (m_fu[head] != sb_pkg::FU_NONE && !m_wb[head]) begin
        write_back(0, head, lcg_next(), 1'b0);
      end
      commit_one();
    end
  endtask

  // lowest issued slot with a matching rd names the writer, x0 never
  task automatic check_clobbers();
    sb_pkg::fu_e exp;
    for (int r = 0; r < 32; r++) begin
      exp = sb_pkg::FU_NONE;
      for (int e = 0; e < 8; e++) begin
        if (r != 0 && m_issued[e] && m_rd[e] == r) begin
          exp = m_fu[e];
          break;
        end
      end
      expect_eq($sformatf("clobber x%0d", r), exp, rd_clobber_o[r]);
    end
  endtask

  task automatic reset_state();
    test_name = "reset";
    rs1_i = 5'd3;
    rs2_i = 5'd4;
    #1;
    expect_eq("commit valid", 0, commit_valid_o);
    expect_eq("full", 0, sb_full_o);
    expect_eq("rs1 valid", 0, rs1_valid_o);
    expect_eq("rs2 valid", 0, rs2_valid_o);
    check_clobbers();
  endtask

  task automatic in_order_flow();
    test_name = "in_order";
    for (int i = 0; i < 4; i++) begin
      issue_one(sb_pkg::FU_NONE, 5'(i + 1));
    end
    // no write-back, FU_NONE entries finish by themselves
    drain();
  endtask

  task automatic full_backpressure();
    test_name = "full";
    while (tail != 0) begin
      issue_one(sb_pkg::FU_NONE, 5'd1);
      commit_one();
    end
    for (int i = 0; i < 8; i++) begin
      issue_one(sb_pkg::FU_ALU, 5'(i + 10));
    end
    @(negedge clk_i);
    decoded_valid_i = 1'b1;
    issue_ack_i = 1'b1;
    #1;
    expect_eq("full flag", 1, sb_full_o);
    expect_eq("issue valid when full", 0, issue_valid_o);
    expect_eq("decoded ack when full", 0, decoded_ack_o);
    // nothing was offered, so the issue stage drops its ack before the edge
    issue_ack_i = 1'b0;
    finish_cycle();
    write_back(0, head, lcg_next(), 1'b0);
    commit_one();
    expect_eq("full after commit", 0, sb_full_o);
    // freed slot 0 is the next one handed out
    expect_eq("wrapped trans id", 0, issue_trans_id_o);
    issue_one(sb_pkg::FU_ALU, 5'd20);
    drain();
  endtask

  task automatic out_of_order_wb();
    int t;
    test_name = "out_of_order";
    t = tail;
    issue_one(sb_pkg::FU_ALU, 5'd5);
    issue_one(sb_pkg::FU_LOAD, 5'd6);
    issue_one(sb_pkg::FU_ALU, 5'd7);
    issue_one(sb_pkg::FU_LOAD, 5'd8);
    // youngest first, one of them faulting
    @(negedge clk_i);
    drive_wb(0, (t + 3) % 8, lcg_next(), 1'b0);
    drive_wb(1, (t + 2) % 8, lcg_next(), 1'b1);
    finish_cycle();
    drive_wb(0, (t + 1) % 8, lcg_next(), 1'b0);
    drive_wb(1, t, lcg_next(), 1'b0);
    finish_cycle();
    drain();
    // slot at the commit pointer is free, its write-back is dropped
    write_back(1, head, lcg_next(), 1'b0);
    expect_eq("write-back to free slot", 0, commit_valid_o);
  endtask

  task automatic clobber_tracking();
    test_name = "clobber";
    issue_one(sb_pkg::FU_ALU, 5'd9);
    issue_one(sb_pkg::FU_MULT, 5'd9);
    issue_one(sb_pkg::FU_LOAD, 5'd0);
    issue_one(sb_pkg::FU_CSR, 5'd21);
    expect_eq("x9 lower slot wins", sb_pkg::FU_ALU, rd_clobber_o[9]);
    expect_eq("x0 never clobbered", sb_pkg::FU_NONE, rd_clobber_o[0]);
    check_clobbers();
    drain();
    check_clobbers();
  endtask

  task automatic forwarding_paths();
    int s0;
    logic [31:0] a, b, c;
    test_name = "forwarding";
    s0 = tail;
    a = lcg_next();
    b = lcg_next();
    c = lcg_next();
    issue_one(sb_pkg::FU_ALU, 5'd12);
    issue_one(sb_pkg::FU_LOAD, 5'd13);
    // completes by itself, so x0 has a done writer in the queue
    issue_one(sb_pkg::FU_NONE, 5'd0);
    write_back(0, s0, a, 1'b0);
    rs1_i = 5'd12;
    rs2_i = 5'd13;
    #1;
    expect_eq("rs1 valid from entry", 1, rs1_valid_o);
    expect_eq("rs1 data from entry", a, rs1_o);
    expect_eq("rs2 valid while pending", 0, rs2_valid_o);
    // port data beats the stored result, faulting data is held back
    @(negedge clk_i);
    drive_wb(0, s0, c, 1'b0);
    drive_wb(1, (s0 + 1) % 8, b, 1'b1);
    #1;
    expect_eq("rs1 valid from port", 1, rs1_valid_o);
    expect_eq("rs1 data from port", c, rs1_o);
    expect_eq("rs2 valid with exception", 0, rs2_valid_o);
    finish_cycle();
    rs1_i = 5'd0;
    rs2_i = 5'd12;
    #1;
    expect_eq("rs1 valid for x0", 0, rs1_valid_o);
    expect_eq("rs2 valid from entry", 1, rs2_valid_o);
    expect_eq("rs2 data from entry", c, rs2_o);
    @(negedge clk_i);
    rs2_i = 5'd25;
    #1;
    expect_eq("rs2 valid unmatched", 0, rs2_valid_o);
    drain();
  endtask

  task automatic flush_controls();
    test_name = "flush";
    @(negedge clk_i);
    decoded_valid_i = 1'b1;
    unresolved_branch_i = 1'b1;
    #1;
    expect_eq("issue valid on branch", 0, issue_valid_o);
    finish_cycle();
    decoded_valid_i = 1'b1;
    issue_ack_i = 1'b1;
    flush_unissued_i = 1'b1;
    decoded_fu_i = sb_pkg::FU_NONE;
    finish_cycle();
    // long enough for a written FU_NONE entry to show up at commit
    finish_cycle();
    expect_eq("trans id after blocked write", tail, issue_trans_id_o);
    expect_eq("blocked write commit valid", 0, commit_valid_o);
    issue_one(sb_pkg::FU_ALU, 5'd3);
    issue_one(sb_pkg::FU_LOAD, 5'd4);
    issue_one(sb_pkg::FU_MULT, 5'd5);
    // oldest entry done, so the flush has a ready commit to discard
    write_back(0, head, lcg_next(), 1'b0);
    expect_eq("commit valid before flush", 1, commit_valid_o);
    check_clobbers();
    @(negedge clk_i);
    flush_i = 1'b1;
    finish_cycle();
    m_issued = '0;
    head = 0;
    tail = 0;
    cnt = 0;
    expect_eq("count after flush", 0, dut0.u_queue_ctrl.cnt_q);
    expect_eq("trans id after flush", 0, issue_trans_id_o);
    expect_eq("commit valid after flush", 0, commit_valid_o);
    check_clobbers();
    issue_one(sb_pkg::FU_NONE, 5'd7);
    commit_one();
  endtask

  initial begin
    errors = 0;
    checks = 0;
    lcg_state = 32'd60;
    head = 0;
    tail = 0;
    cnt = 0;
    m_issued = '0;
    m_wb = '0;
    m_ex = '0;
    rst_ni = 1'b0;
    decoded_valid_i = 1'b0;
    unresolved_branch_i = 1'b0;
    issue_ack_i = 1'b0;
    flush_unissued_i = 1'b0;
    commit_ack_i = 1'b0;
    flush_i = 1'b0;
    decoded_fu_i = sb_pkg::FU_NONE;
    decoded_rd_i = '0;
    rs1_i = '0;
    rs2_i = '0;
    wb_valid_i = '0;
    wb_ex_i = '0;
    wb_trans_id_i = '0;
    wb_data_i = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    reset_state();
    in_order_flow();
    full_backpressure();
    out_of_order_wb();
    clobber_tracking();
    forwarding_paths();
    flush_controls();
    $display("tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- scoreboard_top.f
source/sb_pkg.sv
source/sb_queue_ctrl.sv
source/sb_entry_store.sv
source/sb_clobber_map.sv
source/sb_operand_fwd.sv
source/scoreboard_top.sv
tests/tb_scoreboard.sv

//--- Makefile
# Verilator build and run of the scoreboard testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_scoreboard \
	  -f scoreboard_top.f --Mdir obj_dir -o tb_scoreboard
	./obj_dir/tb_scoreboard | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
